// ==== rtl/filter_pkg.sv ====
// filter package: RGB565 pixel, channel, window and kernel weight types
package filter_pkg;

	// channel widths of an RGB565 pixel
	localparam int RED_W = 5;
	localparam int GREEN_W = 6;
	localparam int BLUE_W = 5;

	typedef logic [RED_W-1:0] red_t;
	typedef logic [GREEN_W-1:0] green_t;
	typedef logic [BLUE_W-1:0] blue_t;

	// red in the top bits, blue in the bottom bits
	typedef struct packed {
		red_t red;
		green_t green;
		blue_t blue;
	} pixel_t;

	// up to 1024 pixels per line
	typedef logic [9:0] column_t;
	typedef logic [9:0] row_t;

	// line store indices, 0..2
	typedef struct packed {
		logic [1:0] oldest;
		logic [1:0] middle;
		logic [1:0] newest;
	} row_order_t;

	// vertical slice of the window, top row first
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bottom;
	} pixel_column_t;

	// signed kernel weight
	typedef logic signed [7:0] weight_t;

endpackage

// ==== rtl/pixel_position_counter.sv ====
// pixel position counter: column and row of the incoming pixel, line end and window full flags
`timescale 1ns/1ps

module pixel_position_counter #(
	parameter int LINE_WIDTH = 720
) (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic start_of_frame,
	output filter_pkg::column_t column,
	output logic line_end,
	output logic window_full
);
	import filter_pkg::*;

	column_t col_q;
	row_t row_q;
	row_t row;
	row_t row_next;

	// start of frame forces the current pixel to column 0, row 0
	assign column = start_of_frame ? '0 : col_q;
	assign row = start_of_frame ? '0 : row_q;

	assign line_end = (column == column_t'(LINE_WIDTH - 1));

	// centre of the window is one row up and one column left
	assign window_full = (row >= row_t'(2)) && (column >= column_t'(2));

	// rows only matter up to 2, so saturate there
	assign row_next = (line_end && (row < row_t'(2))) ? row + row_t'(1) : row;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			col_q <= '0;
			row_q <= '0;
		end else if (pixel_valid) begin
			row_q <= row_next;
			if (line_end) begin
				col_q <= '0;
			end else begin
				col_q <= column + column_t'(1);
			end
		end
	end

	// wrap must happen before the line store runs out of entries
	column_in_range: assert property (@(posedge clk) disable iff (reset)
		col_q < column_t'(LINE_WIDTH));

endmodule

// ==== rtl/row_rotation_fsm.sv ====
// row rotation FSM: one-hot ring over the three line stores and the row order they give
`timescale 1ns/1ps

module row_rotation_fsm (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic line_end,
	input logic start_of_frame,
	output logic [2:0] write_select,
	output filter_pkg::row_order_t row_order
);

	logic [2:0] state_q;

	// first pixel of a frame always goes to store 0
	assign write_select = start_of_frame ? 3'b001 : state_q;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= 3'b001;
		end else if (pixel_valid) begin
			// next line goes to the next store in the ring
			state_q <= line_end ? {write_select[1:0], write_select[2]} : write_select;
		end
	end

	// store k is written, k-1 holds the previous line, k+1 the one before it
	always_comb begin
		case (write_select)
			3'b010: begin
				row_order.oldest = 2'd2;
				row_order.middle = 2'd0;
				row_order.newest = 2'd1;
			end
			3'b100: begin
				row_order.oldest = 2'd0;
				row_order.middle = 2'd1;
				row_order.newest = 2'd2;
			end
			default: begin
				row_order.oldest = 2'd1;
				row_order.middle = 2'd2;
				row_order.newest = 2'd0;
			end
		endcase
	end

	write_select_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot(write_select));

endmodule

// ==== rtl/line_store.sv ====
// line store: one image line of pixels, single port, read before write
`timescale 1ns/1ps

module line_store #(
	parameter int LINE_WIDTH = 720
) (
	input logic clk,
	input logic write_enable,
	input filter_pkg::column_t address,
	input filter_pkg::pixel_t write_data,
	output filter_pkg::pixel_t read_data
);
	import filter_pkg::*;

	// address bits actually needed for the line
	localparam int ADDR_W = (LINE_WIDTH > 1) ? $clog2(LINE_WIDTH) : 1;

	pixel_t mem [LINE_WIDTH];
	logic [ADDR_W-1:0] addr;

	assign addr = address[ADDR_W-1:0];

	// old pixel comes out while the new one goes in
	always_ff @(posedge clk) begin
		read_data <= mem[addr];
		if (write_enable) begin
			mem[addr] <= write_data;
		end
	end

endmodule

// ==== rtl/window_assembler.sv ====
// window assembler: orders the stored rows and shifts columns into the 3x3 window
`timescale 1ns/1ps

module window_assembler (
	input logic clk,
	input logic reset,
	input logic shift,
	input filter_pkg::pixel_t stored [3],
	input filter_pkg::pixel_t current,
	input filter_pkg::row_order_t row_order,
	output filter_pkg::pixel_column_t window [3]
);
	import filter_pkg::*;

	logic shift_q;
	row_order_t order_q;
	pixel_column_t incoming;

	// store read data arrives one cycle after the pixel
	// so the shift and the row order wait one cycle too
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			shift_q <= 1'b0;
			order_q <= '0;
		end else begin
			shift_q <= shift;
			if (shift) begin
				order_q <= row_order;
			end
		end
	end

	// two lines back on top, current pixel at the bottom
	always_comb begin
		incoming.top = stored[order_q.oldest];
		incoming.mid = stored[order_q.middle];
		incoming.bottom = current;
	end

	// index 0 is the left column, new column enters at the right
	always_ff @(posedge clk) begin
		if (shift_q) begin
			window[0] <= window[1];
			window[1] <= window[2];
			window[2] <= incoming;
		end
	end

endmodule

// ==== rtl/channel_convolver.sv ====
// channel convolver: weighted 3x3 sum for one colour channel, wrapped and registered
`timescale 1ns/1ps

module channel_convolver #(
	parameter type chan_t = logic [4:0],
	parameter filter_pkg::weight_t W_CORNER = 0,
	parameter filter_pkg::weight_t W_EDGE = 1,
	parameter filter_pkg::weight_t W_CENTER = -4
) (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic window_full,
	input chan_t taps [9],
	output chan_t result,
	output logic out_valid
);
	import filter_pkg::*;

	// four taps times a weight, plus headroom for the sum of three terms
	localparam int ACC_W = $bits(chan_t) + $bits(weight_t) + 4;

	typedef logic signed [ACC_W-1:0] acc_t;

	acc_t corner_sum;
	acc_t edge_sum;
	acc_t centre_val;
	acc_t total;

	// taps row by row, 0 top left, 4 centre, 8 bottom right
	always_comb begin
		corner_sum = acc_t'(taps[0]) + acc_t'(taps[2]) + acc_t'(taps[6]) + acc_t'(taps[8]);
		edge_sum = acc_t'(taps[1]) + acc_t'(taps[3]) + acc_t'(taps[5]) + acc_t'(taps[7]);
		centre_val = acc_t'(taps[4]);
		total = acc_t'(W_CORNER) * corner_sum + acc_t'(W_EDGE) * edge_sum +
			acc_t'(W_CENTER) * centre_val;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	// border windows give zero, the rest wraps to channel width
	always_ff @(posedge clk) begin
		if (in_valid) begin
			result <= window_full ? chan_t'(total) : '0;
		end
	end

endmodule

// ==== rtl/laplace_filter_top.sv ====
// laplace filter top: streaming 3x3 convolution of RGB565 pixels over three line stores
`timescale 1ns/1ps

module laplace_filter_top #(
	parameter int LINE_WIDTH = 720,
	parameter filter_pkg::weight_t W_CORNER = 0,
	parameter filter_pkg::weight_t W_EDGE = 1,
	parameter filter_pkg::weight_t W_CENTER = -4
) (
	input logic clk,
	input logic reset,
	input logic start_of_frame,
	input logic pixel_valid,
	input filter_pkg::pixel_t pixel_in,
	output logic out_valid,
	output filter_pkg::pixel_t out_pixel
);
	import filter_pkg::*;

	column_t column;
	logic line_end;
	logic window_full;
	logic [2:0] write_select;
	row_order_t row_order;
	pixel_t stored [3];
	pixel_t pixel_q;
	pixel_column_t window [3];

	// valid and border flag follow the pixel through two stages
	logic [1:0] valid_pipe;
	logic [1:0] full_pipe;

	red_t red_taps [9];
	green_t green_taps [9];
	blue_t blue_taps [9];
	red_t red_result;
	green_t green_result;
	blue_t blue_result;

	pixel_position_counter #(
		.LINE_WIDTH(LINE_WIDTH)
	) pixel_position_counter_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.start_of_frame(start_of_frame),
		.column(column),
		.line_end(line_end),
		.window_full(window_full)
	);

	row_rotation_fsm row_rotation_fsm_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.line_end(line_end),
		.start_of_frame(start_of_frame),
		.write_select(write_select),
		.row_order(row_order)
	);

	for (genvar i = 0; i < 3; i++) begin : g_store
		line_store #(
			.LINE_WIDTH(LINE_WIDTH)
		) line_store_i (
			.clk(clk),
			.write_enable(pixel_valid & write_select[i]),
			.address(column),
			.write_data(pixel_in),
			.read_data(stored[i])
		);
	end

	// current pixel lines up with the store read data
	always_ff @(posedge clk) begin
		if (pixel_valid) begin
			pixel_q <= pixel_in;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
			full_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[0], pixel_valid};
			full_pipe <= {full_pipe[0], window_full};
		end
	end

	window_assembler window_assembler_i (
		.clk(clk),
		.reset(reset),
		.shift(pixel_valid),
		.stored(stored),
		.current(pixel_q),
		.row_order(row_order),
		.window(window)
	);

	// split the window per channel, row by row
	always_comb begin
		for (int c = 0; c < 3; c++) begin
			red_taps[c] = window[c].top.red;
			red_taps[3 + c] = window[c].mid.red;
			red_taps[6 + c] = window[c].bottom.red;
			green_taps[c] = window[c].top.green;
			green_taps[3 + c] = window[c].mid.green;
			green_taps[6 + c] = window[c].bottom.green;
			blue_taps[c] = window[c].top.blue;
			blue_taps[3 + c] = window[c].mid.blue;
			blue_taps[6 + c] = window[c].bottom.blue;
		end
	end

	// red instance owns the output strobe
	channel_convolver #(
		.chan_t(red_t),
		.W_CORNER(W_CORNER),
		.W_EDGE(W_EDGE),
		.W_CENTER(W_CENTER)
	) red_convolver_i (
		.clk(clk),
		.reset(reset),
		.in_valid(valid_pipe[1]),
		.window_full(full_pipe[1]),
		.taps(red_taps),
		.result(red_result),
		.out_valid(out_valid)
	);

	channel_convolver #(
		.chan_t(green_t),
		.W_CORNER(W_CORNER),
		.W_EDGE(W_EDGE),
		.W_CENTER(W_CENTER)
	) green_convolver_i (
		.clk(clk),
		.reset(reset),
		.in_valid(valid_pipe[1]),
		.window_full(full_pipe[1]),
		.taps(green_taps),
		.result(green_result),
		.out_valid()
	);

	channel_convolver #(
		.chan_t(blue_t),
		.W_CORNER(W_CORNER),
		.W_EDGE(W_EDGE),
		.W_CENTER(W_CENTER)
	) blue_convolver_i (
		.clk(clk),
		.reset(reset),
		.in_valid(valid_pipe[1]),
		.window_full(full_pipe[1]),
		.taps(blue_taps),
		.result(blue_result),
		.out_valid()
	);

	assign out_pixel = {red_result, green_result, blue_result};

	// out_valid rises on the second edge after the pixel
	// so the sampled strobe shows it one edge later
	pixel_latency: assert property (@(posedge clk) disable iff (reset)
		pixel_valid |-> ##3 out_valid);

endmodule

// ==== dv/filter_checker.sv ====
// filter checker: watches the filter outputs and compares them with the expected pixels
`timescale 1ns/1ps

module filter_checker (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input logic expect_push,
	input filter_pkg::pixel_t expect_pixel,
	input logic out_valid,
	input filter_pkg::pixel_t out_pixel,
	output logic drained,
	output int check_count,
	output int error_count
);
	import filter_pkg::*;

	// expected outputs in arrival order
	pixel_t expected_q [$];
	pixel_t expected;

	// accepted pixel strobes of the last three edges
	logic [2:0] accept_hist;

	always @(posedge clk or posedge reset) begin
		if (reset) begin
			accept_hist = '0;
			expected_q.delete();
			check_count = 0;
			error_count = 0;
		end else begin
			// out_valid is registered two edges after the pixel
			// and so is seen here on the third edge
			if (out_valid && !accept_hist[2]) begin
				$display("Error at %0d ns: extra out_valid with no pixel accepted two edges before",
					$time);
				error_count = error_count + 1;
			end else if (!out_valid && accept_hist[2]) begin
				$display("Error at %0d ns: out_valid missing for a pixel accepted two edges before",
					$time);
				error_count = error_count + 1;
				// drop the lost output so later pixels stay aligned
				if (expected_q.size() > 0) begin
					void'(expected_q.pop_front());
				end
			end else if (out_valid) begin
				if (expected_q.size() == 0) begin
					$display("Error at %0d ns: out_valid pulsed but no expected pixel is queued",
						$time);
					error_count = error_count + 1;
				end else begin
					expected = expected_q.pop_front();
					check_count = check_count + 1;
					if (out_pixel !== expected) begin
						$display("Mismatch at %0d ns: out_pixel expected %04h got %04h",
							$time, expected, out_pixel);
						error_count = error_count + 1;
					end
				end
			end

			// new expectation comes with the pixel itself
			if (expect_push) begin
				expected_q.push_back(expect_pixel);
			end
			accept_hist = {accept_hist[1:0], pixel_valid};
		end
		drained = (expected_q.size() == 0);
	end

endmodule

// ==== dv/tb_laplace_filter.sv ====
// testbench for the laplace filter: golden frames in, filtered pixels checked by the checker
`timescale 1ns/1ps

module tb_laplace_filter;
	import filter_pkg::*;

	localparam int LINE_WIDTH = 8;
	localparam int FRAME_PIXELS = 32;
	localparam int NUM_ENTRIES = 64;
	localparam int CLK_PERIOD = 100;
	localparam int MAX_GAP = 2;
	// four cycles per pixel covers the widest gap, plus reset and drain
	localparam int TIMEOUT_NS = (NUM_ENTRIES * 4 + 20) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic start_of_frame;
	logic pixel_valid;
	pixel_t pixel_in;
	logic out_valid;
	pixel_t out_pixel;

	logic expect_push;
	pixel_t expect_pixel;
	logic drained;
	int check_count;
	int error_count;

	// upper half input pixel, lower half expected output
	logic [31:0] golden [NUM_ENTRIES];

	int tests_run;
	int tests_failed;
	int errors_before;
	logic load_failed;

	laplace_filter_top #(
		.LINE_WIDTH(LINE_WIDTH)
	) laplace_filter_top_i (
		.clk(clk),
		.reset(reset),
		.start_of_frame(start_of_frame),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.out_valid(out_valid),
		.out_pixel(out_pixel)
	);

	filter_checker filter_checker_i (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.expect_push(expect_push),
		.expect_pixel(expect_pixel),
		.out_valid(out_valid),
		.out_pixel(out_pixel),
		.drained(drained),
		.check_count(check_count),
		.error_count(error_count)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// one pixel on the falling edge, then a random run of idle cycles
	task automatic drive_pixel(input int index, input logic frame_start);
		int gap;
		gap = int'($urandom % (MAX_GAP + 1));
		pixel_valid = 1'b1;
		start_of_frame = frame_start;
		pixel_in = golden[index][31:16];
		expect_push = 1'b1;
		expect_pixel = golden[index][15:0];
		@(negedge clk);
		pixel_valid = 1'b0;
		start_of_frame = 1'b0;
		expect_push = 1'b0;
		repeat (gap) @(negedge clk);
	endtask

	// whole frame in raster order, start of frame on its first pixel
	task automatic send_frame(input int first);
		for (int i = 0; i < FRAME_PIXELS; i++) begin
			drive_pixel(first + i, i == 0);
		end
	endtask

	// checker counts only settle between rising edges
	task automatic wait_for_drain();
		while (!drained) @(negedge clk);
	endtask

	task automatic report_test(input string name, input int errors_at_start);
		tests_run = tests_run + 1;
		if (error_count == errors_at_start) begin
			$display("test %s finished with no errors", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("test %s finished with %0d errors", name, error_count - errors_at_start);
		end
	endtask

	initial begin
		void'($urandom(32'h59e5));
		reset = 1'b1;
		start_of_frame = 1'b0;
		pixel_valid = 1'b0;
		pixel_in = '0;
		expect_push = 1'b0;
		expect_pixel = '0;
		tests_run = 0;
		tests_failed = 0;
		load_failed = 1'b0;

		$readmemh("dv/golden_frames.hex", golden);
		if ($isunknown(golden[0]) || $isunknown(golden[NUM_ENTRIES - 1])) begin
			$display("golden file dv/golden_frames.hex is missing or too short");
			load_failed = 1'b1;
		end

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// idle after reset, any out_valid here is an extra pulse
		errors_before = error_count;
		repeat (4) @(negedge clk);
		report_test("reset_idle", errors_before);

		errors_before = error_count;
		send_frame(0);
		wait_for_drain();
		report_test("frame_0", errors_before);

		// second frame restarts position and rotation mid stream
		errors_before = error_count;
		send_frame(FRAME_PIXELS);
		wait_for_drain();
		report_test("frame_1", errors_before);

		$display("tests run %0d, tests failed %0d, outputs checked %0d, errors %0d",
			tests_run, tests_failed, check_count, error_count);
		if (tests_failed == 0 && error_count == 0 && !load_failed) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout after %0d ns, the filter did not deliver every expected output",
			TIMEOUT_NS);
		$display("Test failures found");
		$finish;
	end

endmodule

// ==== all.f ====
rtl/filter_pkg.sv
rtl/pixel_position_counter.sv
rtl/row_rotation_fsm.sv
rtl/line_store.sv
rtl/window_assembler.sv
rtl/channel_convolver.sv
rtl/laplace_filter_top.sv
dv/filter_checker.sv
dv/tb_laplace_filter.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing -j 0 --top-module tb_laplace_filter -f all.f -o sim_laplace \
	|| { echo "verilator build failed"; exit 1; }
./obj_dir/sim_laplace | tee /dev/stderr | grep -q "All tests passed!" \
	&& echo "simulation result: pass" || { echo "simulation result: fail"; exit 1; }

// ==== dv/golden_frames.hex ====
// columns: input pixel rgb565 (upper four digits), expected output rgb565 (lower four digits)
// two 8x4 frames in raster order, frame 0 on lines 0 to 31, frame 1 on lines 32 to 63
29690000
32680000
6BA10000
052E0000
2EE90000
10EC0000
EB310000
E5B20000
41AB0000
52AB0000
93E50000
35730000
672F0000
51330000
33790000
35FB0000
8B710000
A4720000
EDAD61DE
973C91D8
C8F9C1D2
C2FEF1CC
AD2521C6
B7A851C0
003B0000
213D0000
7279635E
23E99358
65A7C352
67ADF34C
51F52346
64795340
8D0D0000
956E0000
88110000
47360000
8D1D0000
33E60000
0E110000
E5BE0000
948F0000
9D930000
90D90000
48810000
970B0000
3E970000
11450000
E9950000
CB1D0000
D4A40000
C88D214E
80F8F38E
C805C5CE
7034900E
4B85624E
2478348E
60830000
6ACD0000
6759515A
1847239A
6017F5DA
08C9C01A
E4DD925A
BE53649A
